// ==== rv_exec_pkg.sv ====
package rv_exec_pkg;

    // ISA widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Major opcodes handled by this pipeline
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct7 patterns, ALT selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_e;

    // Decode to execute
    typedef struct packed {
        logic                  valid;
        alu_op_e               op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;
        logic                  illegal;
    } decoded_op_t;

    // Execute to result
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
        logic                  illegal;
    } exec_result_t;

    // Retired instruction as seen outside the core
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
        logic [XLEN-1:0]       order;
    } commit_t;

endpackage

// ==== rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
    input  logic                         itf,
    input  logic                         reset,
    input  logic                         instr_valid,
    input  logic [rv_exec_pkg::XLEN-1:0] instr,
    output rv_exec_pkg::decoded_op_t     dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       op_legal;
    rv_exec_pkg::decoded_op_t next_dec;

    // funct3 to ALU operation, alt picks SUB or SRA
    function automatic rv_exec_pkg::alu_op_e base_op(input logic [2:0] f3, input logic alt);
        rv_exec_pkg::alu_op_e op;
        case (f3)
            3'b000: op = alt ? rv_exec_pkg::SUB : rv_exec_pkg::ADD;
            3'b001: op = rv_exec_pkg::SLL;
            3'b010: op = rv_exec_pkg::SLT;
            3'b011: op = rv_exec_pkg::SLTU;
            3'b100: op = rv_exec_pkg::XOR;
            3'b101: op = alt ? rv_exec_pkg::SRA : rv_exec_pkg::SRL;
            3'b110: op = rv_exec_pkg::OR;
            default: op = rv_exec_pkg::AND;
        endcase
        return op;
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Only SUB and SRA may use the alternate funct7
    assign op_legal = (funct7 == rv_exec_pkg::F7_BASE) ||
                      ((funct7 == rv_exec_pkg::F7_ALT) &&
                       ((funct3 == 3'b000) || (funct3 == 3'b101)));

    always_comb begin
        next_dec         = '0;
        next_dec.valid   = instr_valid;
        next_dec.rs1     = instr[19:15];
        next_dec.rs2     = instr[24:20];
        next_dec.rd      = instr[11:7];
        // Sign-extended I-type immediate
        next_dec.imm     = {{20{instr[31]}}, instr[31:20]};
        next_dec.op      = rv_exec_pkg::ADD;
        next_dec.use_imm = 1'b0;
        next_dec.illegal = 1'b0;
        case (opcode)
            rv_exec_pkg::OPC_OP: begin
                next_dec.op      = base_op(funct3, funct7[5]);
                next_dec.illegal = !op_legal;
            end
            rv_exec_pkg::OPC_OP_IMM: begin
                next_dec.use_imm = 1'b1;
                // Only right shifts look at imm bit 10, no SUBI exists
                next_dec.op      = base_op(funct3, (funct3 == 3'b101) && instr[30]);
            end
            default: begin
                next_dec.illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge itf) begin
        if (reset) begin
            dec <= '0;
        end else begin
            dec <= next_dec;
        end
    end

endmodule

// ==== rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
    input  logic                                itf,
    input  logic                                reset,
    input  rv_exec_pkg::decoded_op_t            dec,
    input  logic [rv_exec_pkg::XLEN-1:0]        rf_rs1_data,
    input  logic [rv_exec_pkg::XLEN-1:0]        rf_rs2_data,
    output logic [rv_exec_pkg::REG_ADDR_W-1:0]  rf_rs1,
    output logic [rv_exec_pkg::REG_ADDR_W-1:0]  rf_rs2,
    input  logic                                wb_valid,
    input  logic [rv_exec_pkg::REG_ADDR_W-1:0]  wb_rd,
    input  logic [rv_exec_pkg::XLEN-1:0]        wb_value,
    output rv_exec_pkg::exec_result_t           ex
);

    logic [rv_exec_pkg::XLEN-1:0] op_a;
    logic [rv_exec_pkg::XLEN-1:0] op_b;
    logic [4:0]                   shamt;
    logic [rv_exec_pkg::XLEN-1:0] alu_out;

    // Operand source, newest producer wins
    function automatic logic [rv_exec_pkg::XLEN-1:0] read_operand(
        input logic [rv_exec_pkg::REG_ADDR_W-1:0] addr,
        input logic [rv_exec_pkg::XLEN-1:0]       rf_data
    );
        logic [rv_exec_pkg::XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (ex.valid && !ex.illegal && (ex.rd == addr)) begin
            // One ahead, still in our output register
            data = ex.value;
        end else if (wb_valid && (wb_rd == addr)) begin
            // Two ahead, write pending in result stage
            data = wb_value;
        end else begin
            data = rf_data;
        end
        return data;
    endfunction

    assign rf_rs1 = dec.rs1;
    assign rf_rs2 = dec.rs2;

    always_comb begin
        op_a  = read_operand(dec.rs1, rf_rs1_data);
        op_b  = dec.use_imm ? dec.imm : read_operand(dec.rs2, rf_rs2_data);
        shamt = op_b[4:0];
        case (dec.op)
            rv_exec_pkg::ADD:  alu_out = op_a + op_b;
            rv_exec_pkg::SUB:  alu_out = op_a - op_b;
            rv_exec_pkg::SLL:  alu_out = op_a << shamt;
            rv_exec_pkg::SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_exec_pkg::SLTU: alu_out = {31'b0, op_a < op_b};
            rv_exec_pkg::XOR:  alu_out = op_a ^ op_b;
            rv_exec_pkg::SRL:  alu_out = op_a >> shamt;
            rv_exec_pkg::SRA:  alu_out = $signed(op_a) >>> shamt;
            rv_exec_pkg::OR:   alu_out = op_a | op_b;
            rv_exec_pkg::AND:  alu_out = op_a & op_b;
            default:           alu_out = '0;
        endcase
    end

    always_ff @(posedge itf) begin
        if (reset) begin
            ex <= '0;
        end else begin
            ex.valid   <= dec.valid;
            ex.rd      <= dec.rd;
            ex.value   <= dec.illegal ? '0 : alu_out;
            ex.illegal <= dec.illegal;
        end
    end

endmodule

// ==== rv_result.sv ====
`timescale 1ns/1ps

module rv_result (
    input  logic                                itf,
    input  logic                                reset,
    input  rv_exec_pkg::exec_result_t           ex,
    input  logic [rv_exec_pkg::REG_ADDR_W-1:0]  rf_rs1,
    input  logic [rv_exec_pkg::REG_ADDR_W-1:0]  rf_rs2,
    output logic [rv_exec_pkg::XLEN-1:0]        rf_rs1_data,
    output logic [rv_exec_pkg::XLEN-1:0]        rf_rs2_data,
    output logic                                wb_valid,
    output logic [rv_exec_pkg::REG_ADDR_W-1:0]  wb_rd,
    output logic [rv_exec_pkg::XLEN-1:0]        wb_value,
    output logic                                commit_valid,
    output rv_exec_pkg::commit_t                commit,
    output logic                                trap
);

    logic [rv_exec_pkg::XLEN-1:0] regs [rv_exec_pkg::NUM_REGS];
    logic [rv_exec_pkg::XLEN-1:0] order_cnt;
    logic                         retire;
    logic                         write_en;

    assign retire   = ex.valid && !ex.illegal;
    // x0 is never written
    assign write_en = retire && (ex.rd != '0);

    // Asynchronous read ports, x0 stays zero
    assign rf_rs1_data = regs[rf_rs1];
    assign rf_rs2_data = regs[rf_rs2];

    // Commit record and write-back captured on the same edge
    always_ff @(posedge itf) begin
        if (reset) begin
            commit_valid <= 1'b0;
            trap         <= 1'b0;
            commit       <= '0;
            order_cnt    <= '0;
            wb_valid     <= 1'b0;
            wb_rd        <= '0;
            wb_value     <= '0;
        end else begin
            commit_valid <= retire;
            trap         <= ex.valid && ex.illegal;
            if (retire) begin
                commit.rd    <= ex.rd;
                commit.value <= (ex.rd == '0) ? '0 : ex.value;
                commit.order <= order_cnt;
                order_cnt    <= order_cnt + 1'b1;
            end
            wb_valid <= write_en;
            wb_rd    <= ex.rd;
            wb_value <= ex.value;
        end
    end

    always_ff @(posedge itf) begin
        if (reset) begin
            for (int i = 0; i < rv_exec_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_rd] <= wb_value;
        end
    end

endmodule

// ==== rv_exec_top.sv ====
`timescale 1ns/1ps

module rv_exec_top (
    input  logic                         itf,
    input  logic                         reset,
    input  logic                         instr_valid,
    input  logic [rv_exec_pkg::XLEN-1:0] instr,
    output logic                         commit_valid,
    output rv_exec_pkg::commit_t         commit,
    output logic                         trap
);

    rv_exec_pkg::decoded_op_t             dec;
    rv_exec_pkg::exec_result_t            ex;
    logic [rv_exec_pkg::REG_ADDR_W-1:0]   rf_rs1;
    logic [rv_exec_pkg::REG_ADDR_W-1:0]   rf_rs2;
    logic [rv_exec_pkg::XLEN-1:0]         rf_rs1_data;
    logic [rv_exec_pkg::XLEN-1:0]         rf_rs2_data;
    // Pending register write, also a forwarding source
    logic                                 wb_valid;
    logic [rv_exec_pkg::REG_ADDR_W-1:0]   wb_rd;
    logic [rv_exec_pkg::XLEN-1:0]         wb_value;

    rv_decode u_decode (
        .itf         (itf),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec         (dec)
    );

    rv_execute u_execute (
        .itf         (itf),
        .reset       (reset),
        .dec         (dec),
        .rf_rs1_data (rf_rs1_data),
        .rf_rs2_data (rf_rs2_data),
        .rf_rs1      (rf_rs1),
        .rf_rs2      (rf_rs2),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_value    (wb_value),
        .ex          (ex)
    );

    rv_result u_result (
        .itf          (itf),
        .reset        (reset),
        .ex           (ex),
        .rf_rs1       (rf_rs1),
        .rf_rs2       (rf_rs2),
        .rf_rs1_data  (rf_rs1_data),
        .rf_rs2_data  (rf_rs2_data),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_value     (wb_value),
        .commit_valid (commit_valid),
        .commit       (commit),
        .trap         (trap)
    );

endmodule

// ==== rv_exec_asserts.sv ====
`timescale 1ns/1ps

module rv_exec_asserts (
    input logic                 itf,
    input logic                 reset,
    input logic                 instr_valid,
    input logic                 commit_valid,
    input rv_exec_pkg::commit_t commit,
    input logic                 trap
);

    logic [rv_exec_pkg::XLEN-1:0] next_order;

    // Order number the next commit must carry
    always_ff @(posedge itf) begin
        if (reset) begin
            next_order <= '0;
        end else if (commit_valid) begin
            next_order <= commit.order + 32'd1;
        end
    end

    assert property (@(posedge itf) disable iff (reset) !(commit_valid && trap))
        else $error("commit_valid and trap high in the same cycle");

    // Each strobe retires as exactly one commit or trap three cycles on
    assert property (@(posedge itf) disable iff (reset)
                     (commit_valid || trap) == $past(instr_valid, 3))
        else $error("retire strobe does not follow the instruction strobe by 3 cycles");

    assert property (@(posedge itf) disable iff (reset)
                     commit_valid |-> (commit.order == next_order))
        else $error("commit order number skipped or repeated");

endmodule

bind rv_exec_top rv_exec_asserts u_asserts (
    .itf          (itf),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .commit_valid (commit_valid),
    .commit       (commit),
    .trap         (trap)
);

// ==== rv_exec_tb.sv ====
`timescale 1ns/1ps

module rv_exec_tb;

    // One expected outcome in issue order
    typedef struct packed {
        logic                 is_trap;
        rv_exec_pkg::commit_t rec;
        logic [31:0]          due;
    } expect_t;

    logic                         itf = 1'b0;
    logic                         reset = 1'b1;
    logic                         instr_valid = 1'b0;
    logic [rv_exec_pkg::XLEN-1:0] instr = '0;
    logic                         commit_valid;
    rv_exec_pkg::commit_t         commit;
    logic                         trap;
    logic [15:0]                  lfsr = 16'd4384;
    logic [31:0]                  cycle = '0;
    logic [31:0]                  model_regs [rv_exec_pkg::NUM_REGS];
    logic [31:0]                  model_order = '0;
    expect_t                      exp_q [$];
    logic                         gaps_on = 1'b0;
    int unsigned                  issued = 0;
    int unsigned                  pass_count = 0;
    int unsigned                  fail_count = 0;
    int unsigned                  test_errors = 0;
    string                        test_name = "reset";
    // Base operation for each funct3
    rv_exec_pkg::alu_op_e         f3_ops [8] = '{rv_exec_pkg::ADD, rv_exec_pkg::SLL,
        rv_exec_pkg::SLT, rv_exec_pkg::SLTU, rv_exec_pkg::XOR, rv_exec_pkg::SRL,
        rv_exec_pkg::OR, rv_exec_pkg::AND};

    rv_exec_top dut (
        .itf          (itf),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .commit_valid (commit_valid),
        .commit       (commit),
        .trap         (trap)
    );

    always #10 itf = ~itf;

    always @(posedge itf) begin
        cycle <= cycle + 32'd1;
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // Mostly x0..x7 so that dependencies are frequent
    function automatic logic [4:0] pick_reg();
        return (take_bits(2) != 0) ? 5'(take_bits(3)) : 5'(take_bits(5));
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv_exec_pkg::OPC_OP_IMM};
    endfunction

    // Operation index k where 8 and 9 select SUB and SRA
    function automatic logic [31:0] rtype(input int k, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [4:0] rd);
        logic [2:0] f3;
        f3 = (k == 8) ? 3'd0 : ((k == 9) ? 3'd5 : 3'(k));
        return {((k > 7) ? 7'h20 : 7'h00), rs2, rs1, f3, rd, rv_exec_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] rand_op(input logic [4:0] rs1);
        return rtype(int'(take_bits(4)) % 10, pick_reg(), rs1, pick_reg());
    endfunction

    function automatic logic [31:0] rand_imm(input logic [4:0] rs1);
        logic [2:0]  f3;
        logic [11:0] imm;
        f3  = 3'(take_bits(3));
        imm = 12'(take_bits(12));
        // Shift immediates hold the shift amount and the SRAI bit only
        imm = (f3 == 3'd5) ? (imm & 12'h41f) : ((f3 == 3'd1) ? (imm & 12'h01f) : imm);
        return enc_i(imm, rs1, f3, pick_reg());
    endfunction

    function automatic logic [31:0] rand_any();
        logic [2:0] sel;
        sel = 3'(take_bits(3));
        if (sel == 3'd0) begin
            return {25'(take_bits(25)), 7'b1100111};
        end
        return (sel < 3'd4) ? rand_op(pick_reg()) : rand_imm(pick_reg());
    endfunction

    // Reference result of one instruction and its register update
    function automatic expect_t model_step(input logic [31:0] ins);
        expect_t              e;
        logic [2:0]           f3;
        logic                 alt;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          res;
        rv_exec_pkg::alu_op_e op;
        e   = '0;
        f3  = ins[14:12];
        a   = model_regs[ins[19:15]];
        b   = model_regs[ins[24:20]];
        alt = ins[30];
        if (ins[6:0] == rv_exec_pkg::OPC_OP) begin
            e.is_trap = (ins[31:25] != 7'h00) &&
                        !((ins[31:25] == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
        end else if (ins[6:0] == rv_exec_pkg::OPC_OP_IMM) begin
            b   = {{20{ins[31]}}, ins[31:20]};
            alt = alt && (f3 == 3'd5);
        end else begin
            e.is_trap = 1'b1;
        end
        op = f3_ops[f3];
        if (alt && op == rv_exec_pkg::ADD) begin
            op = rv_exec_pkg::SUB;
        end else if (alt && op == rv_exec_pkg::SRL) begin
            op = rv_exec_pkg::SRA;
        end
        case (op)
            rv_exec_pkg::ADD:  res = a + b;
            rv_exec_pkg::SUB:  res = a + ~b + 32'd1;
            rv_exec_pkg::SLL:  res = a << b[4:0];
            rv_exec_pkg::SLT:  res = {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
            rv_exec_pkg::SLTU: res = {31'd0, a < b};
            rv_exec_pkg::XOR:  res = a ^ b;
            rv_exec_pkg::SRL:  res = a >> b[4:0];
            rv_exec_pkg::SRA:  res = (a >> b[4:0]) | (a[31] ? ~(32'hffffffff >> b[4:0]) : '0);
            rv_exec_pkg::OR:   res = a | b;
            default:           res = a & b;
        endcase
        if (!e.is_trap) begin
            if (ins[11:7] != 5'd0) begin
                model_regs[ins[11:7]] = res;
            end
            e.rec.rd    = ins[11:7];
            e.rec.value = (ins[11:7] == 5'd0) ? 32'd0 : res;
            e.rec.order = model_order;
            model_order = model_order + 32'd1;
        end
        return e;
    endfunction

    task automatic tally(input logic ok);
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
            test_errors++;
        end
    endtask

    task automatic check_commit(input rv_exec_pkg::commit_t exp,
                                input rv_exec_pkg::commit_t act);
        tally(exp == act);
        if (exp != act) begin
            $display("[FAIL] %s: expected rd=%0d val=%h ord=%0d, actual rd=%0d val=%h ord=%0d",
                     test_name, exp.rd, exp.value, exp.order, act.rd, act.value, act.order);
        end
    endtask

    task automatic check_trap(input logic exp_trap, input logic act_trap);
        tally(exp_trap == act_trap);
        if (exp_trap != act_trap) begin
            $display("%s: trap %s at cycle %0d", test_name,
                     exp_trap ? "missing" : "raised unexpectedly", cycle);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge itf);
            instr_valid = 1'b0;
        end
    endtask

    // Result is due 3 cycles after the drive edge
    task automatic issue(input logic [31:0] ins);
        expect_t e;
        if (gaps_on) begin
            idle(int'(take_bits(2)) % 3);
        end
        @(negedge itf);
        e     = model_step(ins);
        e.due = cycle + 32'd3;
        exp_q.push_back(e);
        instr_valid = 1'b1;
        instr       = ins;
        issued++;
    endtask

    task automatic finish_test();
        idle(1);
        while (exp_q.size() != 0) begin
            @(negedge itf);
        end
        idle(1);
        $display("%s finished with %0d errors", test_name, test_errors);
        test_errors = 0;
    endtask

    // Retire outputs matched against the expected queue
    always @(negedge itf) begin
        expect_t e;
        if (!reset) begin
            if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
                e = exp_q.pop_front();
                check_trap(e.is_trap, trap);
                if (e.is_trap == commit_valid) begin
                    tally(1'b0);
                    $display("%s: commit %s at cycle %0d", test_name,
                             commit_valid ? "not expected" : "missing", cycle);
                end else if (commit_valid) begin
                    check_commit(e.rec, commit);
                end
            end else if (commit_valid || trap) begin
                tally(1'b0);
                $display("%s: output at cycle %0d with no instruction due", test_name, cycle);
            end
        end
    end

    initial begin
        logic [31:0] ins;
        for (int i = 0; i < rv_exec_pkg::NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge itf);
        @(negedge itf);
        reset = 1'b0;

        // x1 = 0x80000000, x2 = -1, x3 = 0x7fffffff
        test_name = "reg_reg";
        issue(enc_i(12'd1, 5'd0, 3'd0, 5'd1));
        issue(enc_i(12'd31, 5'd1, 3'd1, 5'd1));
        issue(enc_i(12'hfff, 5'd0, 3'd0, 5'd2));
        issue(enc_i(12'd1, 5'd2, 3'd5, 5'd3));
        for (int k = 0; k < 10; k++) begin
            issue(rtype(k, 5'd1, 5'd3, 5'd4));
            issue(rtype(k, 5'd2, 5'd1, 5'd5));
        end
        repeat (30) issue(rand_op(pick_reg()));
        finish_test();

        // x1 = -2048 so that SRLI and SRAI differ
        test_name = "imm_ops";
        issue(enc_i(12'h800, 5'd0, 3'd0, 5'd1));
        issue(enc_i(12'h004, 5'd1, 3'd5, 5'd4));
        issue(enc_i(12'h404, 5'd1, 3'd5, 5'd5));
        issue(enc_i(12'h800, 5'd3, 3'd2, 5'd6));
        gaps_on = 1'b1;
        repeat (40) issue(rand_imm(pick_reg()));
        finish_test();

        // x5 chain with 0, 1 and 2 idle cycles between producer and consumer
        test_name = "forwarding";
        gaps_on = 1'b0;
        for (int g = 0; g < 3; g++) begin
            repeat (4) begin
                issue(enc_i(12'(take_bits(12)), 5'd5, 3'd0, 5'd5));
                idle(g);
            end
        end
        gaps_on = 1'b1;
        ins = rand_op(5'd5);
        repeat (40) begin
            issue(ins);
            ins = take_bits(1) ? rand_op(ins[11:7]) : rand_imm(ins[11:7]);
        end
        finish_test();

        test_name = "x0_writes";
        gaps_on = 1'b0;
        issue(enc_i(12'd123, 5'd0, 3'd0, 5'd0));
        issue(rtype(0, 5'd2, 5'd1, 5'd0));
        issue(rtype(6, 5'd0, 5'd0, 5'd4));
        issue(enc_i(12'd5, 5'd0, 3'd6, 5'd4));
        finish_test();

        // x6 gets a known value that no illegal word may change
        test_name = "illegal";
        issue(enc_i(12'h2a5, 5'd0, 3'd0, 5'd6));
        issue({7'h20, 5'd2, 5'd1, 3'd4, 5'd6, rv_exec_pkg::OPC_OP});
        repeat (12) begin
            ins       = take_bits(32);
            ins[11:7] = 5'd6;
            if (take_bits(1)) begin
                ins[6:0] = rv_exec_pkg::OPC_OP;
                ins[25]  = 1'b1;
            end else if (ins[6:0] == rv_exec_pkg::OPC_OP ||
                         ins[6:0] == rv_exec_pkg::OPC_OP_IMM) begin
                ins[6] = 1'b1;
            end
            issue(ins);
            issue(enc_i(12'd0, 5'd6, 3'd0, 5'd7));
        end
        finish_test();

        test_name = "latency_stream";
        repeat (40) issue(rand_any());
        gaps_on = 1'b1;
        repeat (40) issue(rand_any());
        finish_test();

        $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count != 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Four cycles per issued instruction plus margin for reset and drains
    initial begin
        while (cycle <= issued * 4 + 300) begin
            @(posedge itf);
        end
        $display("Timeout: no progress after %0d cycles with %0d instructions", cycle, issued);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== all.f ====
rv_exec_pkg.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_exec_top.sv
rv_exec_asserts.sv
rv_exec_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line appears in the output
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -j 0 --top-module rv_exec_tb -f all.f -o rv_exec_sim &&
./obj_dir/rv_exec_sim +verilator+error+limit+100 | tee /dev/stderr |
    grep -qx "Test completed successfully" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
